//--- kp_pkg.sv
package kp_pkg;

    localparam int FRAME_DIM = 16;

    typedef logic [7:0] pixel_t;          // also the threshold
    typedef logic [7:0] addr_t;           // row * dim + col
    typedef logic [3:0] coord_t;
    typedef logic signed [8:0] dog_t;

    typedef struct packed {
        coord_t row;
        coord_t col;
    } kp_t;

    typedef enum logic [2:0] {
        st_idle,
        st_load,
        st_blur,
        st_detect,
        st_end
    } seq_state_t;

endpackage

//--- kp_cfg.sv
module kp_cfg (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cfg_we,
    input  kp_pkg::pixel_t cfg_threshold,
    input  logic           busy,
    output kp_pkg::pixel_t threshold
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            threshold <= 8'd16;
        end else if (cfg_we && !busy) begin   // frozen while a frame runs
            threshold <= cfg_threshold;
        end
    end

endmodule

//--- frame_mem.sv
module frame_mem #(
    parameter int depth = 256
) (
    input  logic           clk,
    input  logic           we,
    input  kp_pkg::addr_t  addr,
    input  kp_pkg::pixel_t din,
    output kp_pkg::pixel_t dout
);

    kp_pkg::pixel_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr];   // old data on a write cycle
    end

endmodule

//--- gauss_blur.sv
module gauss_blur #(
    parameter int frame_dim = kp_pkg::FRAME_DIM
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    output logic           done,
    output kp_pkg::addr_t  rd_addr,
    input  kp_pkg::pixel_t rd_data,
    output logic           wr_en,
    output kp_pkg::addr_t  wr_addr,
    output kp_pkg::pixel_t wr_data
);

    localparam int lg       = $clog2(frame_dim);
    localparam int n_pix    = frame_dim * frame_dim;
    localparam int last_idx = n_pix + frame_dim;   // newest tap of the last centre

    logic           active;
    logic [8:0]     cnt;
    logic           b_vld;
    logic [8:0]     b_idx;
    logic           w_vld;
    logic [8:0]     w_idx;
    kp_pkg::pixel_t win [3][3];               // [row][col] with col 0 the newest
    kp_pkg::pixel_t lb_mid [frame_dim-3];
    kp_pkg::pixel_t lb_top [frame_dim-3];
    kp_pkg::pixel_t tap [3][3];
    kp_pkg::addr_t  c_addr;
    kp_pkg::coord_t c_row;
    kp_pkg::coord_t c_col;
    logic [11:0]    sum;

    assign rd_addr = kp_pkg::addr_t'(cnt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (start) begin
            active <= 1'b1;
            cnt    <= '0;
        end else if (active) begin
            if (cnt == 9'(last_idx)) begin
                active <= 1'b0;
            end else begin
                cnt <= cnt + 9'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            b_vld <= 1'b0;
            w_vld <= 1'b0;
        end else begin
            b_vld <= active;
            w_vld <= b_vld;
        end
    end

    always_ff @(posedge clk) begin
        b_idx <= cnt;
        if (b_vld) begin
            w_idx <= b_idx;
            for (int r = 0; r < 3; r++) begin
                for (int c = 1; c < 3; c++) begin
                    win[r][c] <= win[r][c-1];
                end
            end
            win[2][0] <= rd_data;
            win[1][0] <= lb_mid[frame_dim-4];
            win[0][0] <= lb_top[frame_dim-4];
            lb_mid[0] <= win[2][2];
            lb_top[0] <= win[1][2];
            for (int i = 1; i < frame_dim - 3; i++) begin
                lb_mid[i] <= lb_mid[i-1];
                lb_top[i] <= lb_top[i-1];
            end
        end
    end

    // centre lags the newest tap by one row and one pixel
    assign c_addr = kp_pkg::addr_t'(w_idx - 9'(frame_dim + 1));
    assign c_row  = kp_pkg::coord_t'(c_addr >> lg);
    assign c_col  = kp_pkg::coord_t'(c_addr[lg-1:0]);

    always_comb begin
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                tap[r][c] = win[r][c];
            end
        end
        for (int i = 0; i < 3; i++) begin
            if (c_row == '0) begin
                tap[0][i] = '0;
            end
            if (c_row == kp_pkg::coord_t'(frame_dim - 1)) begin
                tap[2][i] = '0;
            end
            if (c_col == '0) begin
                tap[i][2] = '0;                 // left neighbour
            end
            if (c_col == kp_pkg::coord_t'(frame_dim - 1)) begin
                tap[i][0] = '0;                 // right neighbour wraps to the next row
            end
        end
    end

    assign sum = 12'(tap[0][0]) + 12'(tap[0][2]) + 12'(tap[2][0]) + 12'(tap[2][2])
               + (12'(tap[0][1]) << 1) + (12'(tap[1][0]) << 1)
               + (12'(tap[1][2]) << 1) + (12'(tap[2][1]) << 1)
               + (12'(tap[1][1]) << 2);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_en <= 1'b0;
            done  <= 1'b0;
        end else begin
            wr_en <= w_vld && (w_idx > 9'(frame_dim));
            done  <= w_vld && (w_idx == 9'(last_idx));
        end
    end

    always_ff @(posedge clk) begin
        wr_addr <= c_addr;
        wr_data <= sum[11:4];                   // divide by 16
    end

endmodule

//--- dog_detect.sv
module dog_detect #(
    parameter int frame_dim = kp_pkg::FRAME_DIM
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           start,
    output logic           done,
    input  kp_pkg::pixel_t threshold,
    output kp_pkg::addr_t  rd_addr,
    input  kp_pkg::pixel_t orig_data,
    input  kp_pkg::pixel_t blur_data,
    input  logic           kp_full,
    output logic           kp_valid,
    output kp_pkg::kp_t    kp
);

    localparam int lg = $clog2(frame_dim);
    localparam kp_pkg::addr_t last_addr = kp_pkg::addr_t'(frame_dim * frame_dim - 1);

    logic          active;
    kp_pkg::addr_t cnt;
    logic          d_vld;
    logic          d_last;
    kp_pkg::addr_t d_addr;
    kp_pkg::dog_t  dog;
    logic [8:0]    mag;

    assign rd_addr = cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            cnt    <= '0;
            d_vld  <= 1'b0;
            d_last <= 1'b0;
        end else begin
            d_vld  <= 1'b0;
            d_last <= 1'b0;
            if (start) begin
                active <= 1'b1;
                cnt    <= '0;
            end else if (active && !kp_full) begin   // hold address on back-pressure
                d_vld <= 1'b1;
                if (cnt == last_addr) begin
                    active <= 1'b0;
                    d_last <= 1'b1;
                end else begin
                    cnt <= cnt + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        d_addr <= cnt;
    end

    assign dog = kp_pkg::dog_t'({1'b0, blur_data}) - kp_pkg::dog_t'({1'b0, orig_data});
    assign mag = dog[8] ? 9'(-dog) : 9'(dog);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kp_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            kp_valid <= d_vld && (mag > {1'b0, threshold});
            done     <= d_last;
        end
    end

    always_ff @(posedge clk) begin
        kp.row <= kp_pkg::coord_t'(d_addr >> lg);
        kp.col <= kp_pkg::coord_t'(d_addr[lg-1:0]);
    end

endmodule

//--- kp_out.sv
module kp_out (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        kp_valid,
    input  kp_pkg::kp_t kp,
    output logic        kp_full,
    output logic        empty,
    output logic        out_req,
    input  logic        out_ack,
    output kp_pkg::kp_t out_data
);

    kp_pkg::kp_t queue [4];
    logic [1:0]  wr_ptr;
    logic [1:0]  rd_ptr;
    logic [2:0]  count;
    logic        acked;
    logic        pop;

    assign pop      = acked && !out_ack;      // ack fell after the req drop
    assign out_data = queue[rd_ptr];
    assign kp_full  = count > 3'd1;           // room for two hits still in flight
    assign empty    = (count == 3'd0) && !out_req && !acked;

    always_ff @(posedge clk) begin
        if (kp_valid) begin
            queue[wr_ptr] <= kp;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            out_req <= 1'b0;
            acked   <= 1'b0;
        end else begin
            if (kp_valid) begin
                wr_ptr <= wr_ptr + 2'd1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
            count <= count + 3'(kp_valid) - 3'(pop);
            if (out_req) begin
                if (out_ack) begin
                    out_req <= 1'b0;
                    acked   <= 1'b1;
                end
            end else if (pop) begin
                acked <= 1'b0;
            end else if (!acked && !out_ack && (count != 3'd0 || kp_valid)) begin
                out_req <= 1'b1;
            end
        end
    end

endmodule

//--- kp_sequencer.sv
module kp_sequencer #(
    parameter int frame_dim = kp_pkg::FRAME_DIM
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    output logic          blur_start,
    input  logic          blur_done,
    output logic          det_start,
    input  logic          det_done,
    input  logic          out_empty,
    output logic          busy,
    input  kp_pkg::addr_t blur_rd_addr,
    input  logic          blur_wr_en,
    input  kp_pkg::addr_t blur_wr_addr,
    input  kp_pkg::addr_t det_addr,
    output logic          orig_we,
    output kp_pkg::addr_t orig_addr,
    output logic          blur_we,
    output kp_pkg::addr_t blur_addr
);

    localparam kp_pkg::addr_t last_pix = kp_pkg::addr_t'(frame_dim * frame_dim - 1);

    kp_pkg::seq_state_t state;
    kp_pkg::seq_state_t next_state;
    kp_pkg::addr_t      load_cnt;
    logic               load_last;
    logic               det_seen;

    assign load_last = in_valid && (load_cnt == last_pix);
    assign busy      = state != kp_pkg::st_idle;

    always_comb begin
        next_state = state;
        case (state)
            kp_pkg::st_idle: begin
                if (in_valid) begin               // first pixel doubles as start
                    next_state = kp_pkg::st_load;
                end
            end
            kp_pkg::st_load: begin
                if (load_last) begin
                    next_state = kp_pkg::st_blur;
                end
            end
            kp_pkg::st_blur: begin
                if (blur_done) begin
                    next_state = kp_pkg::st_detect;
                end
            end
            kp_pkg::st_detect: begin
                if (det_seen && out_empty) begin  // last handshake finished
                    next_state = kp_pkg::st_end;
                end
            end
            default: next_state = kp_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= kp_pkg::st_idle;
            load_cnt   <= '0;
            det_seen   <= 1'b0;
            blur_start <= 1'b0;
            det_start  <= 1'b0;
        end else begin
            state      <= next_state;
            blur_start <= (state == kp_pkg::st_load) && load_last;
            det_start  <= (state == kp_pkg::st_blur) && blur_done;
            if (orig_we) begin
                load_cnt <= load_last ? '0 : load_cnt + 8'd1;
            end
            if (state != kp_pkg::st_detect) begin
                det_seen <= 1'b0;
            end else if (det_done) begin
                det_seen <= 1'b1;
            end
        end
    end

    // memory ports follow the pass that owns the phase
    always_comb begin
        orig_we   = 1'b0;
        orig_addr = load_cnt;
        blur_we   = 1'b0;
        blur_addr = '0;
        case (state)
            kp_pkg::st_idle, kp_pkg::st_load: begin
                orig_we = in_valid;
            end
            kp_pkg::st_blur: begin
                orig_addr = blur_rd_addr;
                blur_we   = blur_wr_en;
                blur_addr = blur_wr_addr;
            end
            kp_pkg::st_detect: begin
                orig_addr = det_addr;
                blur_addr = det_addr;
            end
            default: begin
                orig_we = 1'b0;
            end
        endcase
    end

endmodule

//--- kp_core.sv
module kp_core #(
    parameter int frame_dim = kp_pkg::FRAME_DIM
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  kp_pkg::pixel_t in_data,
    input  logic           cfg_we,
    input  kp_pkg::pixel_t cfg_threshold,
    input  logic           out_ack,
    output logic           out_req,
    output kp_pkg::kp_t    out_data,
    output logic           busy
);

    kp_pkg::pixel_t threshold;
    logic           orig_we;
    kp_pkg::addr_t  orig_addr;
    kp_pkg::pixel_t orig_dout;
    logic           blur_we;
    kp_pkg::addr_t  blur_addr;
    kp_pkg::pixel_t blur_din;
    kp_pkg::pixel_t blur_dout;
    logic           blur_start;
    logic           blur_done;
    kp_pkg::addr_t  blur_rd_addr;
    logic           blur_wr_en;
    kp_pkg::addr_t  blur_wr_addr;
    logic           det_start;
    logic           det_done;
    kp_pkg::addr_t  det_addr;
    logic           kp_valid;
    kp_pkg::kp_t    kp;
    logic           kp_full;
    logic           out_empty;

    kp_cfg cfg_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_we        (cfg_we),
        .cfg_threshold (cfg_threshold),
        .busy          (busy),
        .threshold     (threshold)
    );

    frame_mem #(.depth(frame_dim * frame_dim)) orig_mem_i (
        .clk  (clk),
        .we   (orig_we),
        .addr (orig_addr),
        .din  (in_data),
        .dout (orig_dout)
    );

    frame_mem #(.depth(frame_dim * frame_dim)) blur_mem_i (
        .clk  (clk),
        .we   (blur_we),
        .addr (blur_addr),
        .din  (blur_din),
        .dout (blur_dout)
    );

    gauss_blur #(.frame_dim(frame_dim)) blur_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (blur_start),
        .done    (blur_done),
        .rd_addr (blur_rd_addr),
        .rd_data (orig_dout),
        .wr_en   (blur_wr_en),
        .wr_addr (blur_wr_addr),
        .wr_data (blur_din)
    );

    dog_detect #(.frame_dim(frame_dim)) detect_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (det_start),
        .done      (det_done),
        .threshold (threshold),
        .rd_addr   (det_addr),
        .orig_data (orig_dout),
        .blur_data (blur_dout),
        .kp_full   (kp_full),
        .kp_valid  (kp_valid),
        .kp        (kp)
    );

    kp_out out_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .kp_valid (kp_valid),
        .kp       (kp),
        .kp_full  (kp_full),
        .empty    (out_empty),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_data (out_data)
    );

    kp_sequencer #(.frame_dim(frame_dim)) seq_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .blur_start   (blur_start),
        .blur_done    (blur_done),
        .det_start    (det_start),
        .det_done     (det_done),
        .out_empty    (out_empty),
        .busy         (busy),
        .blur_rd_addr (blur_rd_addr),
        .blur_wr_en   (blur_wr_en),
        .blur_wr_addr (blur_wr_addr),
        .det_addr     (det_addr),
        .orig_we      (orig_we),
        .orig_addr    (orig_addr),
        .blur_we      (blur_we),
        .blur_addr    (blur_addr)
    );

endmodule

//--- kp_core_props.sv
module kp_core_props (
    input logic        clk,
    input logic        rst_n,
    input logic        in_valid,
    input logic        busy,
    input logic        out_req,
    input logic        out_ack,
    input kp_pkg::kp_t out_data
);

    int assert_fails = 0;

    // data frozen from req rise until ack falls
    data_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (out_req || out_ack) |=> $stable(out_data))
        else begin
            assert_fails++;
            $error("out_data changed during a handshake");
        end

    req_rise_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_req) |-> !$past(out_ack))
        else begin
            assert_fails++;
            $error("out_req rose while out_ack was still high");
        end

    req_drop_a: assert property (@(posedge clk) disable iff (!rst_n)
        (out_req && out_ack) |=> !out_req)
        else begin
            assert_fails++;
            $error("out_req stayed high after out_ack");
        end

    leave_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> $past(in_valid))
        else begin
            assert_fails++;
            $error("sequencer left idle without in_valid");
        end

endmodule

bind kp_core kp_core_props props_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .busy     (busy),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data)
);

//--- tb_kp_core.sv
module tb_kp_core;

    localparam int period       = 100;
    localparam int drive_delay  = 10;
    localparam int frame_pix    = kp_pkg::FRAME_DIM * kp_pkg::FRAME_DIM;
    localparam int n_frames     = 5;
    localparam int frame_budget = frame_pix * 4 + 1024;   // cycles per frame
    localparam int data_words   = 281;
    localparam logic [31:0] seed_init = 32'hc3ff_521c;
    localparam string data_file = "kp_input.txt";

    logic           clk;
    logic           rst_n;
    logic           in_valid;
    kp_pkg::pixel_t in_data;
    logic           cfg_we;
    kp_pkg::pixel_t cfg_threshold;
    logic           out_ack;
    logic           out_req;
    kp_pkg::kp_t    out_data;
    logic           busy;

    kp_pkg::pixel_t data_mem [data_words];
    kp_pkg::pixel_t frame_a [frame_pix];
    kp_pkg::pixel_t frame_buf [frame_pix];
    kp_pkg::kp_t    tmp_q [$];
    kp_pkg::kp_t    list_a [$];
    kp_pkg::kp_t    list_b [$];
    kp_pkg::kp_t    list_u [$];
    kp_pkg::kp_t    exp_q [$];                 // what the responder expects next
    kp_pkg::pixel_t thr_a;
    kp_pkg::pixel_t thr_b;
    kp_pkg::pixel_t thr_u;
    kp_pkg::pixel_t uni_val;
    kp_pkg::pixel_t cnt_a;
    kp_pkg::pixel_t cnt_b;
    kp_pkg::pixel_t cnt_u;
    integer         seed;
    int             rd_pos = 0;
    int             errors = 0;
    int             checks = 0;
    int             rx_count = 0;
    int             slow_left = 0;
    int             frames_done = 0;

    kp_core #(.frame_dim(kp_pkg::FRAME_DIM)) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .cfg_we        (cfg_we),
        .cfg_threshold (cfg_threshold),
        .out_ack       (out_ack),
        .out_req       (out_req),
        .out_data      (out_data),
        .busy          (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic check_kp(input string name, input kp_pkg::kp_t got, input kp_pkg::kp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_pixel(input string name, input kp_pkg::pixel_t got,
                               input kp_pkg::pixel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic take(output kp_pkg::pixel_t w);
        w = data_mem[rd_pos];
        rd_pos++;
    endtask

    task automatic read_list(output kp_pkg::pixel_t cnt);
        kp_pkg::pixel_t w;
        int             k;
        take(cnt);
        tmp_q.delete();
        for (k = 0; k < int'(cnt); k++) begin
            take(w);
            tmp_q.push_back(kp_pkg::kp_t'(w));
        end
    endtask

    task automatic parse_input();
        int k;
        take(thr_a);
        take(thr_b);
        for (k = 0; k < frame_pix; k++) begin
            take(frame_a[k]);
        end
        read_list(cnt_a);
        list_a = tmp_q;
        read_list(cnt_b);
        list_b = tmp_q;
        take(uni_val);
        take(thr_u);
        read_list(cnt_u);
        list_u = tmp_q;
        if (rd_pos != data_words || $isunknown(cnt_u)) begin
            errors++;
            $display("input file %s is missing or has the wrong layout", data_file);
        end
    endtask

    task automatic write_threshold(input kp_pkg::pixel_t thr);
        cfg_we        = 1'b1;
        cfg_threshold = thr;
        tick();
        cfg_we = 1'b0;
    endtask

    // random idle gaps and an optional config write at pixel cfg_at
    task automatic stream_frame(input int cfg_at, input kp_pkg::pixel_t late_thr);
        int i;
        for (i = 0; i < frame_pix; i++) begin
            if (i != 0 && ($random(seed) & 3) == 0) begin
                in_valid = 1'b0;
                tick();
            end
            in_valid      = 1'b1;
            in_data       = frame_buf[i];
            cfg_we        = (i == cfg_at);
            cfg_threshold = late_thr;
            tick();
        end
        in_valid = 1'b0;
        cfg_we   = 1'b0;
    endtask

    task automatic run_frame(input kp_pkg::pixel_t thr, input int cfg_at,
                             input kp_pkg::pixel_t late_thr, input int slow,
                             input kp_pkg::pixel_t exp_cnt);
        rx_count = 0;
        write_threshold(thr);
        slow_left = slow;
        stream_frame(cfg_at, late_thr);
        check_bit("busy", busy, 1'b1);
        while (busy) begin
            tick();
        end
        check_pixel("keypoint count", kp_pkg::pixel_t'(rx_count), exp_cnt);
        check_bit("out_req", out_req, 1'b0);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected keypoints never arrived", exp_q.size());
        end
        frames_done++;
    endtask

    // host side of the four-phase handshake
    initial begin
        int          d;
        kp_pkg::kp_t got;
        out_ack = 1'b0;
        forever begin
            tick();
            if (out_req) begin
                if (slow_left > 0) begin
                    d = 20;
                    slow_left--;
                end else begin
                    d = $random(seed) & 3;
                end
                repeat (d) tick();
                got = out_data;
                rx_count++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected keypoint %02h at %0t, none was left to expect", got,
                             $time);
                end else begin
                    check_kp("out_data", got, exp_q.pop_front());
                end
                out_ack = 1'b1;
                tick();
                while (out_req) begin
                    tick();
                end
                out_ack = 1'b0;
            end
        end
    end

    initial begin
        #(longint'(n_frames) * frame_budget * period);
        $display("timeout: run did not finish within %0d cycles", n_frames * frame_budget);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int k;
        seed          = seed_init;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_data       = '0;
        cfg_we        = 1'b0;
        cfg_threshold = '0;
        $readmemh(data_file, data_mem);
        parse_input();
        repeat (8) tick();
        rst_n = 1'b1;
        tick();
        check_bit("out_req", out_req, 1'b0);
        check_bit("busy", busy, 1'b0);

        frame_buf = frame_a;
        exp_q = list_a;
        run_frame(thr_a, -1, thr_a, 0, cnt_a);
        exp_q = list_b;
        run_frame(thr_b, -1, thr_b, 0, cnt_b);        // higher threshold gives fewer hits
        exp_q = list_a;
        run_frame(thr_a, 100, thr_b, 0, cnt_a);       // write while busy is dropped
        exp_q = list_a;
        run_frame(thr_a, -1, thr_a, 4, cnt_a);        // slow host fills the queue

        for (k = 0; k < frame_pix; k++) begin
            frame_buf[k] = uni_val;
        end
        exp_q = list_u;
        run_frame(thr_u, -1, thr_u, 0, cnt_u);

        errors = errors + dut_i.props_i.assert_fails;
        $display("summary: %0d frames, %0d checks, %0d errors", frames_done, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- kp_core.f
kp_pkg.sv
kp_cfg.sv
frame_mem.sv
gauss_blur.sv
dog_detect.sv
kp_out.sv
kp_sequencer.sv
kp_core.sv
kp_core_props.sv
tb_kp_core.sv

//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := tb_kp_core
FILELIST := kp_core.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN) kp_input.txt
	./$(BIN) | tee $(LOG)
	grep -q '^TB PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- kp_input.txt
// hex bytes in order: thr_a thr_b, then 16 rows of 16 pixels
// then count_a + keypoints {row,col}, count_b + keypoints, uniform frame section
18 60
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 ff 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 50 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 c8 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 80 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
// keypoints at thr_a
0c
24 33 34 35 44 7a 9d ac ad ae bd c2
// keypoints at thr_b
02
34 ad
// uniform value, its threshold, count and keypoints
40 14
04
00 0f f0 ff
